// File: Makefile
# Verilator build and run of the M-mode CSR block testbench
# Run from the project root so the stimulus file path resolves

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_csr
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/csr_access_check.sv
// Access checker for CSR requests, purely combinational
// Flags unknown CSRs, low privilege and writes to read-only CSRs

`timescale 1ns/1ns
`default_nettype none

module csr_access_check (
  input  logic [1:0]    current_priv,  // Privilege of the issuing instruction
  csr_req_if.check      req
);
  import csr_map_pkg::*;

  logic known;      // Address is implemented
  logic priv_ok;    // Privilege high enough
  logic read_only;  // No writes allowed

  // ==========================================================
  // Address decode
  // ==========================================================
  always_comb begin
    case (req.addr.raw)
      csr_mstatus, csr_misa, csr_mie, csr_mtvec,
      csr_mscratch, csr_mepc, csr_mcause, csr_mtval,
      csr_mvendorid, csr_marchid, csr_mimpid, csr_mhartid: known = 1'b1;
      default:                                               known = 1'b0;
    endcase
  end

  // Privilege from bits 9:8 of the address
  assign priv_ok = (current_priv >= req.addr.f.priv);

  // ID block by encoding, misa by choice of this core
  assign read_only = (req.addr.f.acc == 2'b11) || (req.addr.raw == csr_misa);

  // Verdict only while a request is present
  assign req.illegal  = req.access && (!known || !priv_ok || (req.we && read_only));
  assign req.write_ok = req.we && req.access && !req.illegal;

endmodule

`default_nettype wire

// File: rtl/csr_map_pkg.sv
// Address map, privilege codes and fixed ID values of the M-mode CSR block
// Shared by the access checker, the register block and the request interface

`default_nettype none

package csr_map_pkg;

  localparam int xlen = 32;  // RV32 only

  // Privilege codes, S-mode not present
  localparam logic [1:0] priv_u = 2'b00;
  localparam logic [1:0] priv_m = 2'b11;

  // ==========================================================
  // Machine-mode CSR addresses
  // ==========================================================
  localparam logic [11:0] csr_mstatus   = 12'h300;
  localparam logic [11:0] csr_misa      = 12'h301;  // Read-only here
  localparam logic [11:0] csr_mie       = 12'h304;
  localparam logic [11:0] csr_mtvec     = 12'h305;
  localparam logic [11:0] csr_mscratch  = 12'h340;
  localparam logic [11:0] csr_mepc      = 12'h341;
  localparam logic [11:0] csr_mcause    = 12'h342;
  localparam logic [11:0] csr_mtval     = 12'h343;
  localparam logic [11:0] csr_mvendorid = 12'hF11;  // ID block, access field 11
  localparam logic [11:0] csr_marchid   = 12'hF12;
  localparam logic [11:0] csr_mimpid    = 12'hF13;
  localparam logic [11:0] csr_mhartid   = 12'hF14;

  // Address word: raw number selects a register, field view carries access rules
  typedef union packed {
    logic [11:0] raw;
    struct packed {
      logic [1:0] acc;   // 11 = read-only
      logic [1:0] priv;  // Lowest privilege allowed
      logic [7:0] idx;   // Register index within the group
    } f;
  } csr_addr_u;

  // Fixed ID contents
  localparam logic [xlen-1:0] misa_value   = 32'h4000_1129;  // MXL=1, I M A F D
  localparam logic [xlen-1:0] mimpid_value = 32'h0000_0001;

endpackage

`default_nettype wire

// File: rtl/csr_reg_pkg.sv
// Register contents of the M-mode CSR block
// mstatus layout, reset and write masks, alignment masks, funct3 op codes

`default_nettype none

package csr_reg_pkg;

  // mstatus fields
  localparam int mstatus_mie_bit  = 3;
  localparam int mstatus_mpie_bit = 7;
  localparam int mstatus_mpp_lsb  = 11;
  localparam int mstatus_mpp_msb  = mstatus_mpp_lsb + 1;  // MPP is 2 bits

  // MPP = M after reset, all else zero
  localparam logic [csr_map_pkg::xlen-1:0] mstatus_reset =
    csr_map_pkg::xlen'(csr_map_pkg::priv_m) << mstatus_mpp_lsb;
  localparam logic [csr_map_pkg::xlen-1:0] mstatus_wmask = 32'h0000_1888;  // MIE MPIE MPP

  // Alignment of the address registers
  localparam logic [csr_map_pkg::xlen-1:0] mtvec_mask = 32'hFFFF_FFFC;  // Direct mode, 4 byte
  localparam logic [csr_map_pkg::xlen-1:0] mepc_mask  = 32'hFFFF_FFFE;  // 2 byte for RVC

  // funct3 of the CSR instructions
  localparam logic [2:0] csr_op_rw  = 3'b001;
  localparam logic [2:0] csr_op_rs  = 3'b010;
  localparam logic [2:0] csr_op_rc  = 3'b011;
  localparam logic [2:0] csr_op_rwi = 3'b101;
  localparam logic [2:0] csr_op_rsi = 3'b110;
  localparam logic [2:0] csr_op_rci = 3'b111;

  localparam int cause_w = 5;  // Exception code width

endpackage

`default_nettype wire

// File: rtl/csr_regs.sv
// Register storage of the M-mode CSRs
// Combinational read mux, read-modify-write per funct3, one-edge write latency
// Priority at the edge: trap load, MRET load, CSR write

`timescale 1ns/1ns
`default_nettype none

module csr_regs (
  input  logic                          clk,
  input  logic                          reset_n,
  csr_req_if.regs                       req,
  csr_trap_if.regs                      trap,
  output logic [csr_map_pkg::xlen-1:0]  rdata,        // Old value, same cycle
  output logic [csr_map_pkg::xlen-1:0]  mepc_out,     // Return address for MRET
  output logic                          mstatus_mie   // Global interrupt enable
);
  import csr_map_pkg::*;
  import csr_reg_pkg::*;

  logic [xlen-1:0] mstatus_q;
  logic [xlen-1:0] mie_q;       // Enable bits, no interrupt sources yet
  logic [xlen-1:0] mtvec_q;
  logic [xlen-1:0] mscratch_q;
  logic [xlen-1:0] mepc_q;
  logic [xlen-1:0] mcause_q;
  logic [xlen-1:0] mtval_q;
  logic [xlen-1:0] wval;        // Result of the op

  // ==========================================================
  // Read mux
  // ==========================================================
  always_comb begin
    case (req.addr.raw)
      csr_mstatus:   rdata = mstatus_q;
      csr_misa:      rdata = misa_value;
      csr_mie:       rdata = mie_q;
      csr_mtvec:     rdata = mtvec_q;
      csr_mscratch:  rdata = mscratch_q;
      csr_mepc:      rdata = mepc_q;
      csr_mcause:    rdata = mcause_q;
      csr_mtval:     rdata = mtval_q;
      csr_mimpid:    rdata = mimpid_value;
      csr_mvendorid,
      csr_marchid,
      csr_mhartid:   rdata = '0;  // Not implemented, single hart
      default:       rdata = '0;  // Unknown, checker flags it
    endcase
  end

  // Replace, set or clear against the old value
  always_comb begin
    case (req.op)
      csr_op_rw, csr_op_rwi: wval = req.wdata;
      csr_op_rs, csr_op_rsi: wval = rdata | req.wdata;
      csr_op_rc, csr_op_rci: wval = rdata & ~req.wdata;
      default:               wval = rdata;  // Reserved funct3
    endcase
  end

  // ==========================================================
  // Update
  // ==========================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mstatus_q  <= mstatus_reset;
      mie_q      <= '0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else if (trap.trap_load) begin
      mepc_q    <= trap.mepc_next;
      mcause_q  <= trap.mcause_next;
      mtval_q   <= trap.mtval_next;
      mstatus_q <= trap.mstatus_next;
    end else if (trap.ret_load) begin
      mstatus_q <= trap.mstatus_next;
    end else if (req.write_ok) begin
      case (req.addr.raw)
        csr_mstatus:  mstatus_q  <= (wval & mstatus_wmask) | (mstatus_q & ~mstatus_wmask);
        csr_mie:      mie_q      <= wval;
        csr_mtvec:    mtvec_q    <= wval & mtvec_mask;
        csr_mscratch: mscratch_q <= wval;
        csr_mepc:     mepc_q     <= wval & mepc_mask;
        csr_mcause:   mcause_q   <= wval;
        csr_mtval:    mtval_q    <= wval;
        default: begin
          // Read-only IDs never get write_ok
        end
      endcase
    end
  end

  // Current state out
  assign trap.mstatus_cur = mstatus_q;
  assign trap.mtvec_cur   = mtvec_q;
  assign mepc_out         = mepc_q;
  assign mstatus_mie      = mstatus_q[mstatus_mie_bit];

endmodule

`default_nettype wire

// File: rtl/csr_req_if.sv
// One CSR instruction request, shared by the access checker and the register block
// The top drives the request fields, the checker returns the verdict

`timescale 1ns/1ns
`default_nettype none

interface csr_req_if;
  import csr_map_pkg::*;

  csr_addr_u        addr;      // CSR number
  logic [2:0]       op;        // funct3
  logic [xlen-1:0]  wdata;     // rs1 value or zero-extended uimm
  logic             access;    // Request valid
  logic             we;        // Instruction writes
  logic             write_ok;  // Only write permission
  logic             illegal;   // Raise illegal instruction

  modport check (input addr, access, we, output illegal, write_ok);
  modport regs  (input addr, op, wdata, write_ok);

endinterface

`default_nettype wire

// File: rtl/csr_top.sv
// Top level of the M-mode CSR block, plain ports toward the core
// Requests are combinational, trap_entry and mret are one-cycle strobes

`timescale 1ns/1ns
`default_nettype none

module csr_top (
  input  logic                            clk,
  input  logic                            reset_n,
  // CSR instruction
  input  logic [11:0]                     csr_addr,
  input  logic [2:0]                      csr_op,        // funct3
  input  logic [csr_map_pkg::xlen-1:0]    csr_wdata,
  input  logic                            csr_access,    // Request valid
  input  logic                            csr_we,
  input  logic [1:0]                      current_priv,
  // Trap entry and return
  input  logic                            trap_entry,
  input  logic [csr_map_pkg::xlen-1:0]    trap_pc,
  input  logic [csr_reg_pkg::cause_w-1:0] trap_cause,
  input  logic [csr_map_pkg::xlen-1:0]    trap_val,
  input  logic                            mret,
  // Results
  output logic [csr_map_pkg::xlen-1:0]    csr_rdata,
  output logic                            illegal_csr,
  output logic [csr_map_pkg::xlen-1:0]    trap_vector,   // mtvec, no delay
  output logic [csr_map_pkg::xlen-1:0]    mepc_out,
  output logic                            mstatus_mie
);

  csr_req_if  req_if ();
  csr_trap_if trap_if ();

  // Request fields from the ports
  assign req_if.addr   = csr_addr;
  assign req_if.op     = csr_op;
  assign req_if.wdata  = csr_wdata;
  assign req_if.access = csr_access;
  assign req_if.we     = csr_we;

  assign illegal_csr = req_if.illegal;
  assign trap_vector = trap_if.mtvec_cur;

  csr_access_check i_csr_access_check (
    .current_priv (current_priv),
    .req          (req_if.check)
  );

  csr_trap_ctrl i_csr_trap_ctrl (
    .trap_entry   (trap_entry),
    .mret         (mret),
    .trap_pc      (trap_pc),
    .trap_cause   (trap_cause),
    .trap_val     (trap_val),
    .current_priv (current_priv),
    .trap         (trap_if.sequencer)
  );

  csr_regs i_csr_regs (
    .clk          (clk),
    .reset_n      (reset_n),
    .req          (req_if.regs),
    .trap         (trap_if.regs),
    .rdata        (csr_rdata),
    .mepc_out     (mepc_out),
    .mstatus_mie  (mstatus_mie)
  );

endmodule

`default_nettype wire

// File: rtl/csr_trap_ctrl.sv
// Trap sequencer, purely combinational
// Builds mepc, mcause, mtval and mstatus updates for trap entry and MRET
// Trap entry wins over MRET in the same cycle

`timescale 1ns/1ns
`default_nettype none

module csr_trap_ctrl (
  input  logic                          trap_entry,    // One-cycle strobe
  input  logic                          mret,          // One-cycle strobe
  input  logic [csr_map_pkg::xlen-1:0]  trap_pc,
  input  logic [csr_reg_pkg::cause_w-1:0] trap_cause,
  input  logic [csr_map_pkg::xlen-1:0]  trap_val,
  input  logic [1:0]                    current_priv,  // Saved into MPP
  csr_trap_if.sequencer                 trap
);
  import csr_map_pkg::*;
  import csr_reg_pkg::*;

  logic [xlen-1:0] status;  // Current mstatus

  assign status = trap.mstatus_cur;

  // Load strobes, MRET dropped under a trap
  assign trap.trap_load = trap_entry;
  assign trap.ret_load  = mret && !trap_entry;

  // ==========================================================
  // Trap entry values
  // ==========================================================
  assign trap.mepc_next   = {trap_pc[xlen-1:1], 1'b0};                  // Halfword aligned
  assign trap.mcause_next = {{(xlen-cause_w){1'b0}}, trap_cause};       // Exceptions only
  assign trap.mtval_next  = trap_val;

  // mstatus stack push on trap, pop on MRET
  always_comb begin
    trap.mstatus_next = status;
    if (trap_entry) begin
      trap.mstatus_next[mstatus_mpie_bit] = status[mstatus_mie_bit];
      trap.mstatus_next[mstatus_mie_bit]  = 1'b0;  // Interrupts off in handler
      trap.mstatus_next[mstatus_mpp_msb:mstatus_mpp_lsb] = current_priv;
    end else if (mret) begin
      trap.mstatus_next[mstatus_mie_bit]  = status[mstatus_mpie_bit];
      trap.mstatus_next[mstatus_mpie_bit] = 1'b1;
      // U-mode is implemented, so MPP drops to U
      trap.mstatus_next[mstatus_mpp_msb:mstatus_mpp_lsb] = priv_u;
    end
  end

endmodule

`default_nettype wire

// File: rtl/csr_trap_if.sv
// Link between the trap sequencer and the register block
// Sequencer presents next values and load strobes, registers return current state

`timescale 1ns/1ns
`default_nettype none

interface csr_trap_if;
  import csr_map_pkg::*;

  logic             trap_load;     // Trap entry this cycle
  logic             ret_load;      // MRET this cycle, no trap
  logic [xlen-1:0]  mepc_next;
  logic [xlen-1:0]  mcause_next;
  logic [xlen-1:0]  mtval_next;
  logic [xlen-1:0]  mstatus_next;  // Valid for either strobe
  logic [xlen-1:0]  mstatus_cur;
  logic [xlen-1:0]  mtvec_cur;

  modport sequencer (
    output trap_load, ret_load, mepc_next, mcause_next, mtval_next, mstatus_next,
    input  mstatus_cur
  );
  modport regs (
    input  trap_load, ret_load, mepc_next, mcause_next, mtval_next, mstatus_next,
    output mstatus_cur, mtvec_cur
  );

endinterface

`default_nettype wire

// File: sim/csr_properties.sv
// Concurrent checks on the CSR top level, bound to csr_top from the testbench
// Illegal flag gating and the effect of trap entry on mstatus and mepc

`timescale 1ns/1ns
`default_nettype none

module csr_properties (
  input logic                         clk,
  input logic                         reset_n,
  input logic                         csr_access,
  input logic                         illegal_csr,
  input logic                         trap_entry,
  input logic [csr_map_pkg::xlen-1:0] trap_pc,
  input logic [csr_map_pkg::xlen-1:0] mepc_out,
  input logic                         mstatus_mie
);
  import csr_map_pkg::*;

  // Verdict only with a request present
  a_illegal_needs_access: assert property (
    @(posedge clk) disable iff (!reset_n) illegal_csr |-> csr_access
  ) else $error("illegal_csr high while csr_access is low");

  // Handler starts with interrupts off
  a_trap_clears_mie: assert property (
    @(posedge clk) disable iff (!reset_n) trap_entry |=> !mstatus_mie
  ) else $error("mstatus_mie still set after trap entry");

  // mepc gets the faulting PC, bit 0 dropped
  a_trap_loads_mepc: assert property (
    @(posedge clk) disable iff (!reset_n)
      trap_entry |=> (mepc_out == ($past(trap_pc) & ~xlen'(1)))
  ) else $error("mepc_out does not match trap_pc after trap entry");

endmodule

`default_nettype wire

// File: sim/csr_stim.txt
# cmd priv addr op wdata exp_rdata exp_illegal, all numbers hex
# trap steps also issue the listed CSR write, which must be discarded
read  3 300 2 00000000 00001800 0
read  3 301 2 00000000 40001129 0
read  3 F13 2 00000000 00000001 0
read  3 340 2 00000000 00000000 0
write 3 340 1 A5A50F0F 00000000 0
write 3 340 2 0000F0F0 A5A50F0F 0
write 3 340 3 A5A50000 A5A5FFFF 0
read  3 340 2 00000000 0000FFFF 0
write 3 340 6 0000001F 0000FFFF 0
write 3 340 7 0000000F 0000FFFF 0
read  3 340 2 00000000 0000FFF0 0
write 3 305 1 FFFFFFFF 00000000 0
write 3 341 1 FFFFFFFF 00000000 0
read  3 305 2 00000000 FFFFFFFC 0
read  3 341 2 00000000 FFFFFFFE 0
write 3 7C0 1 12345678 00000000 1
write 3 F14 1 12345678 00000000 1
read  0 300 2 00000000 00001800 1
read  3 340 2 00000000 0000FFF0 0
write 3 300 1 00000008 00001800 0
read  3 300 2 00000000 00000008 0
trap  3 340 1 DEADBEEF 0000FFF0 0
read  3 300 2 00000000 00001880 0
read  3 341 2 00000000 80000106 0
read  3 342 2 00000000 00000002 0
read  3 343 2 00000000 0000BEEF 0
read  3 340 2 00000000 0000FFF0 0
mret  3 300 0 00000000 00001880 0
read  3 300 2 00000000 00000088 0

// File: sim/tb_clock.sv
// Clock and reset source for the CSR testbench
// 40 ns clock, reset_n held low for the first 5 rising edges

`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk,
  output logic reset_n
);
  localparam int half_period  = 20;  // 40 ns period
  localparam int reset_cycles = 5;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    reset_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    reset_n <= 1'b1;  // Release on an edge, clean for the flops
  end

endmodule

`default_nettype wire

// File: sim/tb_csr.sv
// Testbench top for the M-mode CSR block
// Replays sim/csr_stim.txt one step per clock and checks every response
// Run from the project root so the stimulus path resolves

`timescale 1ns/1ns
`default_nettype none

module tb_csr;
  import csr_map_pkg::*;
  import csr_reg_pkg::*;

  // Fixed trap payload, the expected register contents sit in the file
  localparam logic [31:0] trap_pc_value    = 32'h8000_0107;
  localparam logic [4:0]  trap_cause_value = 5'd2;  // Illegal instruction
  localparam logic [31:0] trap_val_value   = 32'h0000_BEEF;
  localparam int          clk_period       = 40;
  localparam int          reset_cycles     = 5;
  localparam string       stim_file        = "sim/csr_stim.txt";

  typedef struct {
    string       cmd;          // read, write, trap or mret
    logic [1:0]  priv;
    logic [11:0] addr;
    logic [2:0]  op;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic        exp_illegal;
  } step_t;

  logic        clk;
  logic        reset_n;
  logic [11:0] csr_addr;
  logic [2:0]  csr_op;
  logic [31:0] csr_wdata;
  logic        csr_access;
  logic        csr_we;
  logic [1:0]  current_priv;
  logic        trap_entry;
  logic [31:0] trap_pc;
  logic [4:0]  trap_cause;
  logic [31:0] trap_val;
  logic        mret;
  logic [31:0] csr_rdata;
  logic        illegal_csr;
  logic [31:0] trap_vector;
  logic [31:0] mepc_out;
  logic        mstatus_mie;

  step_t steps[$];
  int    errors;
  int    checks;
  int    step_idx;
  int    timeout_ns;
  bit    loaded;

  tb_clock i_tb_clock (
    .clk     (clk),
    .reset_n (reset_n)
  );

  csr_top i_csr_top (
    .clk          (clk),
    .reset_n      (reset_n),
    .csr_addr     (csr_addr),
    .csr_op       (csr_op),
    .csr_wdata    (csr_wdata),
    .csr_access   (csr_access),
    .csr_we       (csr_we),
    .current_priv (current_priv),
    .trap_entry   (trap_entry),
    .trap_pc      (trap_pc),
    .trap_cause   (trap_cause),
    .trap_val     (trap_val),
    .mret         (mret),
    .csr_rdata    (csr_rdata),
    .illegal_csr  (illegal_csr),
    .trap_vector  (trap_vector),
    .mepc_out     (mepc_out),
    .mstatus_mie  (mstatus_mie)
  );

  bind csr_top csr_properties i_csr_properties (
    .clk         (clk),
    .reset_n     (reset_n),
    .csr_access  (csr_access),
    .illegal_csr (illegal_csr),
    .trap_entry  (trap_entry),
    .trap_pc     (trap_pc),
    .mepc_out    (mepc_out),
    .mstatus_mie (mstatus_mie)
  );

  // ==========================================================
  // Helpers
  // ==========================================================
  task automatic load_stimulus();
    int    fd;
    int    rc;
    string line;
    step_t s;
    fd = $fopen(stim_file, "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file %s", stim_file);
      return;
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc > 0) begin
        // Comment and blank lines never yield seven fields
        rc = $sscanf(line, "%s %h %h %h %h %h %h", s.cmd, s.priv, s.addr, s.op,
                     s.wdata, s.exp_rdata, s.exp_illegal);
        if (rc == 7 && s.cmd != "#")
          steps.push_back(s);
      end
    end
    $fclose(fd);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s at step %0d: got 0x%h, expected 0x%h",
               name, step_idx, actual, expected);
    end
  endtask

  // New inputs land on the rising edge, flops still see the old ones
  task automatic apply_step(input step_t s);
    @(posedge clk);
    csr_addr     <= s.addr;
    csr_op       <= s.op;
    csr_wdata    <= s.wdata;
    current_priv <= s.priv;
    csr_access   <= (s.cmd == "read") || (s.cmd == "write") || (s.cmd == "trap");
    csr_we       <= (s.cmd == "write") || (s.cmd == "trap");
    trap_entry   <= (s.cmd == "trap");
    mret         <= (s.cmd == "mret");
    if (s.cmd != "read" && s.cmd != "write" && s.cmd != "trap" && s.cmd != "mret") begin
      errors++;
      $display("Unknown command '%s' at step %0d", s.cmd, step_idx);
    end
  endtask

  task automatic check_step(input step_t s);
    check_value("csr_rdata", csr_rdata, s.exp_rdata);
    check_value("illegal_csr", 32'(illegal_csr), 32'(s.exp_illegal));
    if (s.cmd == "read") begin
      if (s.addr == csr_mtvec)
        check_value("trap_vector", trap_vector, s.exp_rdata);  // Same as mtvec
      if (s.addr == csr_mepc)
        check_value("mepc_out", mepc_out, s.exp_rdata);
      if (s.addr == csr_mstatus)
        check_value("mstatus_mie", 32'(mstatus_mie), 32'(s.exp_rdata[mstatus_mie_bit]));
    end
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin : main
    csr_addr     = '0;
    csr_op       = '0;
    csr_wdata    = '0;
    csr_access   = 1'b0;
    csr_we       = 1'b0;
    current_priv = priv_m;
    trap_entry   = 1'b0;
    trap_pc      = trap_pc_value;     // Payload constant, only the strobe moves
    trap_cause   = trap_cause_value;
    trap_val     = trap_val_value;
    mret         = 1'b0;
    errors       = 0;
    checks       = 0;
    step_idx     = 0;
    load_stimulus();
    timeout_ns = (steps.size() * 3 + reset_cycles) * clk_period;
    loaded     = 1'b1;
    if (steps.size() == 0) begin
      errors++;
      $display("No stimulus steps were loaded");
    end else begin
      wait (reset_n === 1'b1);
      foreach (steps[i]) begin
        step_idx = i;
        apply_step(steps[i]);
        @(negedge clk);  // Mid-cycle, combinational outputs settled
        check_step(steps[i]);
      end
    end
    $display("Steps: %0d, checks: %0d, errors: %0d", steps.size(), checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog, three clocks per step plus reset
  initial begin : watchdog
    wait (loaded);
    #(timeout_ns);
    $display("Timeout after %0d ns, stimulus did not complete", timeout_ns);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
rtl/csr_map_pkg.sv
rtl/csr_reg_pkg.sv
rtl/csr_req_if.sv
rtl/csr_trap_if.sv
rtl/csr_access_check.sv
rtl/csr_trap_ctrl.sv
rtl/csr_regs.sv
rtl/csr_top.sv
sim/tb_clock.sv
sim/csr_properties.sv
sim/tb_csr.sv
